// ==== Bender.yml ====
package:
  name: rename_unit

sources:
  - logic/rename_pkg.sv
  - logic/rename_ctrl.sv
  - logic/map_table.sv
  - logic/free_list.sv
  - logic/prf.sv
  - logic/rename_unit.sv
  - target: simulation
    files:
      - testbench/tb_rename_unit.sv

// ==== logic/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module free_list #(
    parameter int NUM_PREGS = 64
) (
    input  logic                 clk,
    input  logic                 arst_n,

    input  logic                 alloc,
    output rename_pkg::preg_id_t alloc_preg,
    output logic                 empty,

    input  logic                 rel_en,
    input  rename_pkg::preg_id_t rel_preg,

    output logic                 init_done
);

    localparam int PTR_W    = $clog2(NUM_PREGS);
    localparam int CNT_W    = $clog2(NUM_PREGS + 1);
    localparam int NUM_FREE = NUM_PREGS - rename_pkg::NUM_GPR;

    rename_pkg::ctrl_state_t state;
    rename_pkg::preg_id_t    queue [NUM_PREGS-1:0];
    rename_pkg::preg_id_t    push_preg;
    logic [PTR_W-1:0]        head;
    logic [PTR_W-1:0]        tail;
    logic [CNT_W-1:0]        count;
    logic                    fill_last;
    logic                    push;
    logic                    pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(NUM_PREGS - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    // Last fill push happens this cycle.
    assign fill_last = (state == rename_pkg::RESET_INIT) && (tail == PTR_W'(NUM_FREE - 1));
    assign init_done = (state == rename_pkg::RUN) || fill_last;

    // While filling, tail doubles as the fill index.
    assign push      = (state == rename_pkg::RESET_INIT) || rel_en;
    assign push_preg = (state == rename_pkg::RESET_INIT) ?
                       rename_pkg::preg_id_t'(rename_pkg::NUM_GPR + int'(tail)) : rel_preg;
    assign pop       = (state == rename_pkg::RUN) && alloc && !empty;

    assign empty      = (count == '0);
    assign alloc_preg = queue[head];

    always_ff @(posedge clk) begin
        if (push) begin
            queue[tail] <= push_preg;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= rename_pkg::RESET_INIT;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (fill_last) begin
                state <= rename_pkg::RUN;
            end
            if (push) begin
                tail <= ptr_inc(tail);
            end
            if (pop) begin
                head <= ptr_inc(head);
            end
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;  // Both or neither.
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module map_table #(
    parameter int NUM_PREGS = 64
) (
    input  logic                 clk,
    input  logic                 arst_n,

    input  rename_pkg::gpr_id_t  rd_gpr1,
    input  rename_pkg::gpr_id_t  rd_gpr2,
    output rename_pkg::preg_id_t rd_preg1,
    output rename_pkg::preg_id_t rd_preg2,

    input  logic                 wr_en,
    input  rename_pkg::gpr_id_t  wr_gpr,
    input  rename_pkg::preg_id_t wr_preg
);

    rename_pkg::preg_id_t map_q [rename_pkg::NUM_GPR-1:0];

    // Reads see the mapping from before this cycle's update.
    assign rd_preg1 = map_q[rd_gpr1];
    assign rd_preg2 = map_q[rd_gpr2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < rename_pkg::NUM_GPR; i++) begin
                map_q[i] <= rename_pkg::preg_id_t'(i);  // Identity mapping.
            end
        end else if (wr_en) begin
            map_q[wr_gpr] <= wr_preg;
        end
    end

endmodule

`default_nettype wire

// ==== logic/prf.sv ====
`timescale 1ns/1ps
`default_nettype none

module prf #(
    parameter int NUM_PREGS = 64,
    parameter int NUM_WB    = 2,
    parameter int NUM_RD    = 2
) (
    input  logic                  clk,
    input  logic                  arst_n,

    input  logic                  wb_en   [NUM_WB-1:0],
    input  rename_pkg::preg_id_t  wb_preg [NUM_WB-1:0],
    input  rename_pkg::reg_data_t wb_data [NUM_WB-1:0],

    input  logic                  rd_en   [NUM_RD-1:0],
    input  rename_pkg::preg_id_t  rd_preg [NUM_RD-1:0],
    output rename_pkg::reg_data_t rd_data [NUM_RD-1:0],

    input  logic                  set_pend_en,
    input  rename_pkg::preg_id_t  set_pend_preg,

    input  rename_pkg::preg_id_t  look_preg1,
    input  rename_pkg::preg_id_t  look_preg2,
    output logic                  pend1,
    output logic                  pend2
);

    rename_pkg::reg_data_t data_q [NUM_PREGS-1:0];
    logic [NUM_PREGS-1:0]  ready_q;
    rename_pkg::reg_data_t rd_byp [NUM_RD-1:0];
    logic                  wb_hit1;
    logic                  wb_hit2;

    always_comb begin
        wb_hit1 = 1'b0;
        wb_hit2 = 1'b0;
        for (int w = 0; w < NUM_WB; w++) begin
            if (wb_en[w] && wb_preg[w] == look_preg1) begin
                wb_hit1 = 1'b1;
            end
            if (wb_en[w] && wb_preg[w] == look_preg2) begin
                wb_hit2 = 1'b1;
            end
        end
    end

    // A write-back in flight counts as ready.
    assign pend1 = ~ready_q[look_preg1] & ~wb_hit1;
    assign pend2 = ~ready_q[look_preg2] & ~wb_hit2;

    // Later ports win when two write-backs hit the same preg.
    always_comb begin
        for (int r = 0; r < NUM_RD; r++) begin
            rd_byp[r] = data_q[rd_preg[r]];
            for (int w = 0; w < NUM_WB; w++) begin
                if (wb_en[w] && wb_preg[w] == rd_preg[r]) begin
                    rd_byp[r] = wb_data[w];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int r = 0; r < NUM_RD; r++) begin
            if (rd_en[r]) begin
                rd_data[r] <= rd_byp[r];  // Holds between requests.
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                data_q[i] <= '0;
            end
        end else begin
            for (int w = 0; w < NUM_WB; w++) begin
                if (wb_en[w]) begin
                    data_q[wb_preg[w]] <= wb_data[w];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready_q <= '1;
        end else begin
            for (int w = 0; w < NUM_WB; w++) begin
                if (wb_en[w]) begin
                    ready_q[wb_preg[w]] <= 1'b1;
                end
            end
            if (set_pend_en) begin
                ready_q[set_pend_preg] <= 1'b0;  // Allocation beats write-back.
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/rename_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_ctrl (
    input  logic                 clk,
    input  logic                 arst_n,

    input  logic                 valid_rn0,
    input  logic                 dst_vld_rn0,
    input  logic                 src1_vld_rn0,
    input  logic                 src2_vld_rn0,

    input  logic                 init_done,
    input  logic                 empty,
    input  rename_pkg::preg_id_t alloc_preg,

    input  rename_pkg::preg_id_t map_psrc1,
    input  rename_pkg::preg_id_t map_psrc2,
    input  logic                 pend1,
    input  logic                 pend2,

    output logic                 stall_rn0,
    output logic                 alloc,

    output logic                 valid_rn1,
    output rename_pkg::preg_id_t pdst_rn1,
    output rename_pkg::preg_id_t psrc1_rn1,
    output rename_pkg::preg_id_t psrc2_rn1,
    output logic                 psrc1_pend_rn1,
    output logic                 psrc2_pend_rn1
);

    rename_pkg::ctrl_state_t state;
    rename_pkg::ctrl_state_t state_nxt;
    logic                    accept_rn0;

    always_comb begin
        state_nxt = state;
        if (state == rename_pkg::RESET_INIT && init_done) begin
            state_nxt = rename_pkg::RUN;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= rename_pkg::RESET_INIT;
        end else begin
            state <= state_nxt;
        end
    end

    // Hold off fetch while filling or when no preg is left for a destination.
    assign stall_rn0  = (state == rename_pkg::RESET_INIT) | (valid_rn0 & dst_vld_rn0 & empty);
    assign accept_rn0 = valid_rn0 & ~stall_rn0;
    assign alloc      = accept_rn0 & dst_vld_rn0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_rn1 <= 1'b0;
        end else begin
            valid_rn1 <= accept_rn0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_rn0) begin
            pdst_rn1       <= alloc_preg;
            psrc1_rn1      <= src1_vld_rn0 ? map_psrc1 : '0;  // Unused source reads as preg 0.
            psrc2_rn1      <= src2_vld_rn0 ? map_psrc2 : '0;
            psrc1_pend_rn1 <= src1_vld_rn0 & pend1;
            psrc2_pend_rn1 <= src2_vld_rn0 & pend2;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // Architectural register ids.
    localparam int GPR_W   = 5;
    localparam int NUM_GPR = 1 << GPR_W;

    // Physical register ids.
    localparam int PREG_W = 6;

    // Register values.
    localparam int DATA_W = 32;

    typedef logic [GPR_W-1:0]  gpr_id_t;
    typedef logic [PREG_W-1:0] preg_id_t;
    typedef logic [DATA_W-1:0] reg_data_t;

    // Shared by the control FSM and the free list fill sequence.
    typedef enum logic [0:0] {
        RESET_INIT = 1'b0,  // Free list is being filled.
        RUN        = 1'b1   // Normal renaming.
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== logic/rename_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_unit #(
    parameter int NUM_PREGS = 64,
    parameter int NUM_WB    = 2,
    parameter int NUM_RD    = 2
) (
    input  logic                  clk,
    input  logic                  arst_n,

    input  logic                  valid_rn0,
    input  logic                  dst_vld_rn0,
    input  rename_pkg::gpr_id_t   dst_gpr_rn0,
    input  logic                  src1_vld_rn0,
    input  rename_pkg::gpr_id_t   src1_gpr_rn0,
    input  logic                  src2_vld_rn0,
    input  rename_pkg::gpr_id_t   src2_gpr_rn0,
    output logic                  stall_rn0,

    output logic                  valid_rn1,
    output rename_pkg::preg_id_t  pdst_rn1,
    output rename_pkg::preg_id_t  psrc1_rn1,
    output logic                  psrc1_pend_rn1,
    output rename_pkg::preg_id_t  psrc2_rn1,
    output logic                  psrc2_pend_rn1,

    input  logic                  wb_en   [NUM_WB-1:0],
    input  rename_pkg::preg_id_t  wb_preg [NUM_WB-1:0],
    input  rename_pkg::reg_data_t wb_data [NUM_WB-1:0],

    input  logic                  rd_en   [NUM_RD-1:0],
    input  rename_pkg::preg_id_t  rd_preg [NUM_RD-1:0],
    output rename_pkg::reg_data_t rd_data [NUM_RD-1:0],

    input  logic                  rel_en,
    input  rename_pkg::preg_id_t  rel_preg
);

    logic                 alloc;
    rename_pkg::preg_id_t alloc_preg;
    logic                 empty;
    logic                 init_done;
    rename_pkg::preg_id_t map_psrc1;
    rename_pkg::preg_id_t map_psrc2;
    logic                 pend1;
    logic                 pend2;

    rename_ctrl ctrl_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .valid_rn0      (valid_rn0),
        .dst_vld_rn0    (dst_vld_rn0),
        .src1_vld_rn0   (src1_vld_rn0),
        .src2_vld_rn0   (src2_vld_rn0),
        .init_done      (init_done),
        .empty          (empty),
        .alloc_preg     (alloc_preg),
        .map_psrc1      (map_psrc1),
        .map_psrc2      (map_psrc2),
        .pend1          (pend1),
        .pend2          (pend2),
        .stall_rn0      (stall_rn0),
        .alloc          (alloc),
        .valid_rn1      (valid_rn1),
        .pdst_rn1       (pdst_rn1),
        .psrc1_rn1      (psrc1_rn1),
        .psrc2_rn1      (psrc2_rn1),
        .psrc1_pend_rn1 (psrc1_pend_rn1),
        .psrc2_pend_rn1 (psrc2_pend_rn1)
    );

    // The allocation strobe also updates the destination mapping.
    map_table #(
        .NUM_PREGS (NUM_PREGS)
    ) map_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_gpr1  (src1_gpr_rn0),
        .rd_gpr2  (src2_gpr_rn0),
        .rd_preg1 (map_psrc1),
        .rd_preg2 (map_psrc2),
        .wr_en    (alloc),
        .wr_gpr   (dst_gpr_rn0),
        .wr_preg  (alloc_preg)
    );

    free_list #(
        .NUM_PREGS (NUM_PREGS)
    ) fl_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .alloc      (alloc),
        .alloc_preg (alloc_preg),
        .empty      (empty),
        .rel_en     (rel_en),
        .rel_preg   (rel_preg),
        .init_done  (init_done)
    );

    prf #(
        .NUM_PREGS (NUM_PREGS),
        .NUM_WB    (NUM_WB),
        .NUM_RD    (NUM_RD)
    ) prf_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .wb_en         (wb_en),
        .wb_preg       (wb_preg),
        .wb_data       (wb_data),
        .rd_en         (rd_en),
        .rd_preg       (rd_preg),
        .rd_data       (rd_data),
        .set_pend_en   (alloc),
        .set_pend_preg (alloc_preg),
        .look_preg1    (map_psrc1),
        .look_preg2    (map_psrc2),
        .pend1         (pend1),
        .pend2         (pend2)
    );

endmodule

`default_nettype wire

// ==== rename_unit.f ====
logic/rename_pkg.sv
logic/rename_ctrl.sv
logic/map_table.sv
logic/free_list.sv
logic/prf.sv
logic/rename_unit.sv
testbench/tb_rename_unit.sv

// ==== testbench/tb_rename_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rename_unit;

    localparam int NUM_PREGS   = 64;
    localparam int NUM_WB      = 2;
    localparam int NUM_RD      = 2;
    localparam int CLK_PERIOD  = 8;
    localparam int SEED        = 22180;
    localparam int RAND_CYCLES = 400;
    localparam int RUN_CYCLES  = 16 + 40 + 8 + 6 + 2 + 36 + RAND_CYCLES;
    localparam int FILL_CYCLES = NUM_PREGS - rename_pkg::NUM_GPR;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  valid_rn0;
    logic                  dst_vld_rn0;
    rename_pkg::gpr_id_t   dst_gpr_rn0;
    logic                  src1_vld_rn0;
    rename_pkg::gpr_id_t   src1_gpr_rn0;
    logic                  src2_vld_rn0;
    rename_pkg::gpr_id_t   src2_gpr_rn0;
    logic                  stall_rn0;
    logic                  valid_rn1;
    rename_pkg::preg_id_t  pdst_rn1;
    rename_pkg::preg_id_t  psrc1_rn1;
    logic                  psrc1_pend_rn1;
    rename_pkg::preg_id_t  psrc2_rn1;
    logic                  psrc2_pend_rn1;
    logic                  wb_en   [NUM_WB-1:0];
    rename_pkg::preg_id_t  wb_preg [NUM_WB-1:0];
    rename_pkg::reg_data_t wb_data [NUM_WB-1:0];
    logic                  rd_en   [NUM_RD-1:0];
    rename_pkg::preg_id_t  rd_preg [NUM_RD-1:0];
    rename_pkg::reg_data_t rd_data [NUM_RD-1:0];
    logic                  rel_en;
    rename_pkg::preg_id_t  rel_preg;

    // Reference model state.
    int                    map_m   [rename_pkg::NUM_GPR];
    bit                    ready_m [NUM_PREGS];
    rename_pkg::reg_data_t data_m  [NUM_PREGS];
    int                    free_q    [$];
    int                    retired_q [$];  // Pregs displaced from the map, waiting for release.
    rename_pkg::reg_data_t rd_last [NUM_RD];  // Last value each read port returned.
    bit                    rd_seen [NUM_RD];
    int                    errors = 0;
    int                    cycles = 0;

    rename_unit #(
        .NUM_PREGS (NUM_PREGS),
        .NUM_WB    (NUM_WB),
        .NUM_RD    (NUM_RD)
    ) dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic flag_error(input string msg);
        errors++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    task automatic clear_inputs();
        valid_rn0    = 1'b0;
        dst_vld_rn0  = 1'b0;
        dst_gpr_rn0  = '0;
        src1_vld_rn0 = 1'b0;
        src1_gpr_rn0 = '0;
        src2_vld_rn0 = 1'b0;
        src2_gpr_rn0 = '0;
        rel_en       = 1'b0;
        rel_preg     = '0;
        for (int w = 0; w < NUM_WB; w++) begin
            wb_en[w]   = 1'b0;
            wb_preg[w] = '0;
            wb_data[w] = '0;
        end
        for (int r = 0; r < NUM_RD; r++) begin
            rd_en[r]   = 1'b0;
            rd_preg[r] = '0;
        end
    endtask

    task automatic drive_rename(input bit dv, input int dg, input bit s1v, input int s1g,
                                input bit s2v, input int s2g);
        valid_rn0    = 1'b1;
        dst_vld_rn0  = dv;
        dst_gpr_rn0  = rename_pkg::gpr_id_t'(dg);
        src1_vld_rn0 = s1v;
        src1_gpr_rn0 = rename_pkg::gpr_id_t'(s1g);
        src2_vld_rn0 = s2v;
        src2_gpr_rn0 = rename_pkg::gpr_id_t'(s2g);
    endtask

    function automatic bit wb_hit(input int p);
        for (int w = 0; w < NUM_WB; w++) begin
            if (wb_en[w] && wb_preg[w] == p) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic rename_pkg::reg_data_t bypassed_data(input int p);
        rename_pkg::reg_data_t v;
        v = data_m[p];
        for (int w = 0; w < NUM_WB; w++) begin
            if (wb_en[w] && wb_preg[w] == p) begin
                v = wb_data[w];
            end
        end
        return v;
    endfunction

    // Inputs are set at a falling edge; checks one clock edge, ends at the next falling edge.
    task automatic run_cycle();
        bit                    dv;
        bit                    exp_stall;
        bit                    acc;
        int                    exp_s1;
        int                    exp_s2;
        int                    exp_d;
        bit                    exp_p1;
        bit                    exp_p2;
        bit                    rd_chk [NUM_RD];
        rename_pkg::reg_data_t exp_rd [NUM_RD];
        #1;
        dv        = valid_rn0 && dst_vld_rn0;
        exp_stall = dv && (free_q.size() == 0);
        acc       = valid_rn0 && !exp_stall;
        exp_s1    = src1_vld_rn0 ? map_m[src1_gpr_rn0] : 0;
        exp_s2    = src2_vld_rn0 ? map_m[src2_gpr_rn0] : 0;
        exp_p1    = src1_vld_rn0 && !ready_m[exp_s1] && !wb_hit(exp_s1);
        exp_p2    = src2_vld_rn0 && !ready_m[exp_s2] && !wb_hit(exp_s2);
        exp_d     = (free_q.size() > 0) ? free_q[0] : -1;
        for (int r = 0; r < NUM_RD; r++) begin
            rd_chk[r] = rd_en[r];
            exp_rd[r] = bypassed_data(rd_preg[r]);
        end
        if (stall_rn0 !== exp_stall) begin
            flag_error($sformatf("stall_rn0 %b, expected %b", stall_rn0, exp_stall));
        end
        @(posedge clk);
        for (int w = 0; w < NUM_WB; w++) begin
            if (wb_en[w]) begin
                data_m[wb_preg[w]]  = wb_data[w];
                ready_m[wb_preg[w]] = 1'b1;
            end
        end
        if (acc && dv) begin
            retired_q.push_back(map_m[dst_gpr_rn0]);
            map_m[dst_gpr_rn0] = free_q.pop_front();
            ready_m[exp_d]     = 1'b0;  // Allocation wins over a write-back.
        end
        if (rel_en) begin
            free_q.push_back(rel_preg);
        end
        @(negedge clk);
        cycles++;
        if (valid_rn1 !== acc) begin
            flag_error($sformatf("valid_rn1 %b, expected %b", valid_rn1, acc));
        end
        if (acc && dv && pdst_rn1 !== exp_d) begin
            flag_error($sformatf("pdst_rn1 %0d, expected %0d", pdst_rn1, exp_d));
        end
        if (acc && (psrc1_rn1 !== exp_s1 || psrc1_pend_rn1 !== exp_p1)) begin
            flag_error($sformatf("src1 %0d/%b, expected %0d/%b",
                                 psrc1_rn1, psrc1_pend_rn1, exp_s1, exp_p1));
        end
        if (acc && (psrc2_rn1 !== exp_s2 || psrc2_pend_rn1 !== exp_p2)) begin
            flag_error($sformatf("src2 %0d/%b, expected %0d/%b",
                                 psrc2_rn1, psrc2_pend_rn1, exp_s2, exp_p2));
        end
        for (int r = 0; r < NUM_RD; r++) begin
            if (rd_chk[r]) begin
                if (rd_data[r] !== exp_rd[r]) begin
                    flag_error($sformatf("rd_data[%0d] %h, expected %h",
                                         r, rd_data[r], exp_rd[r]));
                end
                rd_last[r] = exp_rd[r];
                rd_seen[r] = 1'b1;
            end else if (rd_seen[r] && rd_data[r] !== rd_last[r]) begin
                flag_error($sformatf("rd_data[%0d] %h changed without a read, expected %h",
                                     r, rd_data[r], rd_last[r]));
            end
        end
        clear_inputs();
    endtask

    task automatic wait_for_init();
        int n;
        n = 0;
        if (valid_rn1 !== 1'b0) begin
            flag_error("valid_rn1 not low after reset");
        end
        while (stall_rn0 !== 1'b0 && n < 40) begin
            n++;
            @(negedge clk);
        end
        if (stall_rn0 !== 1'b0) begin
            errors++;
            $display("Free list fill never finished, stall_rn0 still high after %0d cycles.", n);
        end else if (n != FILL_CYCLES) begin
            flag_error($sformatf("stall_rn0 high for %0d cycles, expected %0d", n, FILL_CYCLES));
        end
    endtask

    task automatic check_identity_after_reset();
        int g1;
        int g2;
        repeat (8) begin
            g1 = $urandom_range(0, 31);
            g2 = $urandom_range(0, 31);
            drive_rename(1'b0, 0, 1'b1, g1, 1'b1, g2);
            run_cycle();
            if (psrc1_rn1 !== g1 || psrc2_rn1 !== g2 ||
                psrc1_pend_rn1 !== 1'b0 || psrc2_pend_rn1 !== 1'b0) begin
                flag_error("sources after reset are not identity mapped and ready");
            end
        end
    endtask

    task automatic allocate_in_order();
        int base;
        base = rename_pkg::NUM_GPR;
        for (int k = 0; k < 4; k++) begin
            drive_rename(1'b1, k + 1, 1'b0, 0, 1'b0, 0);
            run_cycle();
            if (pdst_rn1 !== base + k) begin
                flag_error($sformatf("pdst_rn1 %0d, expected %0d", pdst_rn1, base + k));
            end
        end
        drive_rename(1'b0, 0, 1'b1, 1, 1'b1, 4);
        run_cycle();
        if (psrc1_rn1 !== base || psrc2_rn1 !== base + 3 ||
            psrc1_pend_rn1 !== 1'b1 || psrc2_pend_rn1 !== 1'b1) begin
            flag_error("renamed sources do not point at the new pending pregs");
        end
        drive_rename(1'b1, 3, 1'b1, 3, 1'b0, 0);
        run_cycle();
        if (psrc1_rn1 !== base + 2 || pdst_rn1 !== base + 4) begin
            flag_error("source equal to its own destination did not get the old mapping");
        end
    endtask

    task automatic writeback_and_read();
        rename_pkg::reg_data_t d;
        int                    p;
        d = $urandom;
        p = map_m[1];
        drive_rename(1'b0, 0, 1'b1, 1, 1'b1, 2);
        wb_en[0]   = 1'b1;
        wb_preg[0] = p;
        wb_data[0] = d;
        rd_en[1]   = 1'b1;
        rd_preg[1] = p;
        run_cycle();
        if (psrc1_pend_rn1 !== 1'b0 || rd_data[1] !== d) begin
            flag_error("same-cycle write-back not bypassed to lookup or read");
        end
        drive_rename(1'b0, 0, 1'b1, 1, 1'b0, 0);
        rd_en[0]   = 1'b1;
        rd_preg[0] = p;
        run_cycle();
        if (psrc1_pend_rn1 !== 1'b0 || rd_data[0] !== d) begin
            flag_error("pend bit or read data wrong after write-back");
        end
    endtask

    task automatic exhaust_free_list();
        int rel_p;
        while (free_q.size() > 0) begin
            drive_rename(1'b1, $urandom_range(1, 31), 1'b1, $urandom_range(0, 31), 1'b0, 0);
            run_cycle();
        end
        drive_rename(1'b0, 0, 1'b1, 5, 1'b0, 0);
        run_cycle();
        if (valid_rn1 !== 1'b1) begin
            flag_error("instruction without destination was stalled");
        end
        drive_rename(1'b1, 5, 1'b0, 0, 1'b0, 0);
        run_cycle();
        if (valid_rn1 !== 1'b0) begin
            flag_error("instruction renamed with an empty free list");
        end
        rel_p = retired_q.pop_front();
        drive_rename(1'b1, 5, 1'b0, 0, 1'b0, 0);
        rel_en   = 1'b1;
        rel_preg = rel_p;
        run_cycle();
        drive_rename(1'b1, 5, 1'b0, 0, 1'b0, 0);
        run_cycle();
        if (valid_rn1 !== 1'b1 || pdst_rn1 !== rel_p) begin
            flag_error($sformatf("held instruction got preg %0d, expected %0d", pdst_rn1, rel_p));
        end
    endtask

    task automatic random_traffic();
        bit held;
        bit drove;
        bit dv;
        bit s1v;
        bit s2v;
        int dg;
        int s1g;
        int s2g;
        held = 1'b0;
        repeat (RAND_CYCLES) begin
            if (!held) begin
                dv  = $urandom_range(0, 9) < 6;
                dg  = $urandom_range(0, 31);
                s1v = $urandom_range(0, 9) < 8;
                s1g = $urandom_range(0, 31);
                s2v = $urandom_range(0, 9) < 5;
                s2g = $urandom_range(0, 31);
            end
            drove = held || ($urandom_range(0, 9) < 7);  // Stalled instructions are held.
            if (drove) begin
                drive_rename(dv, dg, s1v, s1g, s2v, s2g);
            end
            for (int w = 0; w < NUM_WB; w++) begin
                wb_en[w]   = $urandom_range(0, 9) < 4;
                wb_preg[w] = $urandom_range(0, NUM_PREGS - 1);
                wb_data[w] = $urandom;
            end
            if (wb_en[0] && wb_en[1] && wb_preg[0] == wb_preg[1]) begin
                wb_en[1] = 1'b0;
            end
            for (int r = 0; r < NUM_RD; r++) begin
                rd_en[r]   = $urandom_range(0, 9) < 5;
                rd_preg[r] = $urandom_range(0, NUM_PREGS - 1);
            end
            if (retired_q.size() > 0 && $urandom_range(0, 9) < 3) begin
                rel_en   = 1'b1;
                rel_preg = retired_q.pop_front();
            end
            run_cycle();
            held = drove && (valid_rn1 !== 1'b1);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        for (int i = 0; i < rename_pkg::NUM_GPR; i++) begin
            map_m[i] = i;
        end
        for (int i = 0; i < NUM_PREGS; i++) begin
            ready_m[i] = 1'b1;
            data_m[i]  = '0;
        end
        for (int i = rename_pkg::NUM_GPR; i < NUM_PREGS; i++) begin
            free_q.push_back(i);
        end
        for (int r = 0; r < NUM_RD; r++) begin
            rd_seen[r] = 1'b0;
            rd_last[r] = '0;
        end
        arst_n = 1'b0;
        clear_inputs();
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        wait_for_init();
        check_identity_after_reset();
        allocate_in_order();
        writeback_and_read();
        exhaust_free_list();
        random_traffic();
        $display("Cycles checked: %0d, errors: %0d", cycles, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD * 2);
        $display("Timeout, the run did not finish within %0d ns.", RUN_CYCLES * CLK_PERIOD * 2);
        $display("Cycles checked: %0d, errors: %0d", cycles, errors);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire
